//--- histTop.f
logic/histPkg.sv
logic/binMapper.sv
logic/histRam.sv
logic/histAccumulator.sv
logic/peakFinder.sv
logic/histTop.sv
verif/histTb.sv

//--- logic/binMapper.sv
`timescale 1ns/1ps

module binMapper import histPkg::*; #(
    parameter int BIN_OFFSET = 0,
    parameter int BIN_SHIFT  = 2
) (
    input  logic             clk,
    input  logic             res,
    input  logic             hit,
    input  logic [TS_W-1:0]  timestamp,
    output logic             binValid,
    output logic [BIN_W-1:0] binAddr
);

    // distance from the window start, signed so early hits go negative
    int delta;
    logic inRange;
    logic [BIN_W-1:0] binNext;

    assign delta = int'(timestamp) - BIN_OFFSET;

    // before the offset, or past the last bin
    assign inRange = (delta >= 0) && ((delta >> BIN_SHIFT) < NUM_BINS);

    // scale to bin units, upper bits are zero when in range
    assign binNext = BIN_W'(delta >> BIN_SHIFT);

    // strobe only for hits that land inside the histogram
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binValid <= 1'b0;
        end else begin
            binValid <= hit && inRange;
        end
    end

    // bin address travels beside the strobe
    always_ff @(posedge clk) begin
        binAddr <= binNext;
    end

endmodule

//--- logic/histAccumulator.sv
`timescale 1ns/1ps

module histAccumulator import histPkg::*; #(
    parameter int COUNT_W = 16
) (
    input  logic               clk,
    input  logic               res,
    input  logic               start,
    input  logic               acqEnd,
    input  logic               binValid,
    input  logic [BIN_W-1:0]   binAddr,
    output logic [BIN_W-1:0]   rdAddrA,
    input  logic [COUNT_W-1:0] rdDataA,
    output logic               wrEn,
    output logic [BIN_W-1:0]   wrAddr,
    output logic [COUNT_W-1:0] wrData,
    output logic               armed,
    output logic               accBusy,
    output logic               histDone
);

    accState_t state;
    logic [BIN_W-1:0] clrAddr;
    logic drainCnt;

    // window flag lined up with binValid, one cycle behind the state
    logic inWin;

    // stage 1 holds the read address, stage 2 waits for the data
    logic s1Valid;
    logic [BIN_W-1:0] s1Addr;
    logic s2Valid;
    logic [BIN_W-1:0] s2Addr;

    // copy of the write the memory took on the last edge
    logic lastValid;
    logic [BIN_W-1:0] lastAddr;
    logic [COUNT_W-1:0] lastData;

    logic fwd;
    logic clearing;
    logic [COUNT_W-1:0] oldCount;
    logic [COUNT_W-1:0] newCount;

    assign clearing = (state == ACC_CLEAR);
    assign armed    = (state == ACC_ACCUM);
    // histDone keeps busy up until the peak finder takes over
    assign accBusy  = (state != ACC_IDLE) || histDone;

    // read issued from stage 1
    assign rdAddrA = s1Addr;

    // read collided with the previous write, memory data is stale
    assign fwd      = lastValid && (lastAddr == s2Addr);
    assign oldCount = fwd ? lastData : rdDataA;
    // saturate at all ones
    assign newCount = (oldCount == {COUNT_W{1'b1}}) ? oldCount : oldCount + 1'b1;

    // clear sweep owns the write port while it runs
    assign wrEn   = clearing || s2Valid;
    assign wrAddr = clearing ? clrAddr : s2Addr;
    assign wrData = clearing ? '0 : newCount;

    // control FSM
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= ACC_IDLE;
            clrAddr  <= '0;
            drainCnt <= 1'b0;
            histDone <= 1'b0;
        end else begin
            histDone <= 1'b0;
            case (state)
                ACC_IDLE: begin
                    // start elsewhere is dropped
                    if (start) begin
                        state   <= ACC_CLEAR;
                        clrAddr <= '0;
                    end
                end
                ACC_CLEAR: begin
                    // one bin zeroed per cycle
                    clrAddr <= clrAddr + 1'b1;
                    if (clrAddr == BIN_W'(NUM_BINS - 1)) begin
                        state <= ACC_ACCUM;
                    end
                end
                ACC_ACCUM: begin
                    if (acqEnd) begin
                        state    <= ACC_DRAIN;
                        drainCnt <= 1'b0;
                    end
                end
                ACC_DRAIN: begin
                    // two cycles lets the last hit reach stage 2
                    drainCnt <= 1'b1;
                    if (drainCnt) begin
                        state    <= ACC_IDLE;
                        histDone <= 1'b1;
                    end
                end
                default: state <= ACC_IDLE;
            endcase
        end
    end

    // pipeline valids
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            inWin     <= 1'b0;
            s1Valid   <= 1'b0;
            s2Valid   <= 1'b0;
            lastValid <= 1'b0;
        end else begin
            inWin     <= (state == ACC_ACCUM);
            s1Valid   <= binValid && inWin;
            s2Valid   <= s1Valid;
            lastValid <= wrEn;
        end
    end

    // addresses and forwarded data
    always_ff @(posedge clk) begin
        s1Addr   <= binAddr;
        s2Addr   <= s1Addr;
        lastAddr <= wrAddr;
        lastData <= wrData;
    end

endmodule

//--- logic/histPkg.sv
package histPkg;

    // timestamp width from the TDC
    localparam int TS_W = 12;

    // bin address width
    localparam int BIN_W = 6;

    // histogram depth follows the address width
    localparam int NUM_BINS = 1 << BIN_W;

    // accumulator control
    // clear sweep, then counting window, then pipeline drain
    typedef enum logic [1:0] {
        ACC_IDLE,
        ACC_CLEAR,
        ACC_ACCUM,
        ACC_DRAIN
    } accState_t;

    // peak search control
    // sweep reads every bin once, report holds one cycle for the pulse
    typedef enum logic [1:0] {
        PK_IDLE,
        PK_SWEEP,
        PK_REPORT
    } peakState_t;

endpackage

//--- logic/histRam.sv
`timescale 1ns/1ps

module histRam import histPkg::*; #(
    parameter int COUNT_W = 16
) (
    input  logic               clk,
    input  logic               wrEn,
    input  logic [BIN_W-1:0]   wrAddr,
    input  logic [COUNT_W-1:0] wrData,
    input  logic [BIN_W-1:0]   rdAddrA,
    output logic [COUNT_W-1:0] rdDataA,
    input  logic [BIN_W-1:0]   rdAddrB,
    output logic [COUNT_W-1:0] rdDataB
);

    // one count per bin
    logic [COUNT_W-1:0] mem [NUM_BINS];

    // write port, shared by clear and accumulate
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered reads
    // same-address read during a write sees the old count
    always_ff @(posedge clk) begin
        rdDataA <= mem[rdAddrA];
        rdDataB <= mem[rdAddrB];
    end

endmodule

//--- logic/histTop.sv
`timescale 1ns/1ps

module histTop import histPkg::*; #(
    parameter int COUNT_W    = 16,
    parameter int BIN_OFFSET = 0,
    parameter int BIN_SHIFT  = 2
) (
    input  logic               clk,
    input  logic               res,
    input  logic               start,
    input  logic               hit,
    input  logic [TS_W-1:0]    timestamp,
    input  logic               acqEnd,
    input  logic [BIN_W-1:0]   rdAddr,
    output logic               armed,
    output logic               busy,
    output logic               histDone,
    output logic               peakValid,
    output logic [BIN_W-1:0]   peakBin,
    output logic [COUNT_W-1:0] peakCount,
    output logic [COUNT_W-1:0] rdData
);

    // mapper to accumulator
    logic binValid;
    logic [BIN_W-1:0] binAddr;

    // memory ports
    logic wrEn;
    logic [BIN_W-1:0] wrAddr;
    logic [COUNT_W-1:0] wrData;
    logic [BIN_W-1:0] rdAddrA;
    logic [COUNT_W-1:0] rdDataA;
    logic [BIN_W-1:0] rdAddrB;

    logic accBusy;
    logic peakBusy;

    assign busy = accBusy || peakBusy;

    binMapper #(.BIN_OFFSET(BIN_OFFSET), .BIN_SHIFT(BIN_SHIFT)) mapper0 (
        .clk(clk), .res(res), .hit(hit), .timestamp(timestamp),
        .binValid(binValid), .binAddr(binAddr)
    );

    histAccumulator #(.COUNT_W(COUNT_W)) acc0 (
        .clk(clk), .res(res), .start(start), .acqEnd(acqEnd),
        .binValid(binValid), .binAddr(binAddr),
        .rdAddrA(rdAddrA), .rdDataA(rdDataA),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .armed(armed), .accBusy(accBusy), .histDone(histDone)
    );

    // port B data doubles as the readout
    histRam #(.COUNT_W(COUNT_W)) ram0 (
        .clk(clk), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdAddrA(rdAddrA), .rdDataA(rdDataA),
        .rdAddrB(rdAddrB), .rdDataB(rdData)
    );

    peakFinder #(.COUNT_W(COUNT_W)) peak0 (
        .clk(clk), .res(res), .histDone(histDone), .rdAddr(rdAddr),
        .rdAddrB(rdAddrB), .rdDataB(rdData), .peakBusy(peakBusy),
        .peakValid(peakValid), .peakBin(peakBin), .peakCount(peakCount)
    );

endmodule

//--- logic/peakFinder.sv
`timescale 1ns/1ps

module peakFinder import histPkg::*; #(
    parameter int COUNT_W = 16
) (
    input  logic               clk,
    input  logic               res,
    input  logic               histDone,
    input  logic [BIN_W-1:0]   rdAddr,
    output logic [BIN_W-1:0]   rdAddrB,
    input  logic [COUNT_W-1:0] rdDataB,
    output logic               peakBusy,
    output logic               peakValid,
    output logic [BIN_W-1:0]   peakBin,
    output logic [COUNT_W-1:0] peakCount
);

    peakState_t state;
    logic [BIN_W-1:0] sweepAddr;

    // address of the data now on rdDataB
    logic cmpValid;
    logic [BIN_W-1:0] cmpAddr;

    // running maximum
    logic [COUNT_W-1:0] runMax;
    logic [BIN_W-1:0] runBin;

    logic better;
    logic [COUNT_W-1:0] nextMax;
    logic [BIN_W-1:0] nextBin;

    // strictly greater, so the lowest bin wins a tie
    assign better  = cmpValid && (rdDataB > runMax);
    assign nextMax = better ? rdDataB : runMax;
    assign nextBin = better ? cmpAddr : runBin;

    // readout port passes through except during the sweep
    assign rdAddrB  = (state == PK_SWEEP) ? sweepAddr : rdAddr;
    assign peakBusy = (state != PK_IDLE);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= PK_IDLE;
            sweepAddr <= '0;
            cmpValid  <= 1'b0;
            runMax    <= '0;
            runBin    <= '0;
            peakValid <= 1'b0;
            peakBin   <= '0;
            peakCount <= '0;
        end else begin
            peakValid <= 1'b0;
            cmpValid  <= (state == PK_SWEEP);
            case (state)
                PK_IDLE: begin
                    if (histDone) begin
                        state     <= PK_SWEEP;
                        sweepAddr <= '0;
                        runMax    <= '0;
                        runBin    <= '0;
                    end
                end
                PK_SWEEP: begin
                    sweepAddr <= sweepAddr + 1'b1;
                    runMax    <= nextMax;
                    runBin    <= nextBin;
                    if (sweepAddr == BIN_W'(NUM_BINS - 1)) begin
                        state <= PK_REPORT;
                    end
                end
                PK_REPORT: begin
                    // last bin compared here, then one cycle holding the pulse
                    if (!peakValid) begin
                        peakValid <= 1'b1;
                        peakBin   <= nextBin;
                        peakCount <= nextMax;
                    end else begin
                        state <= PK_IDLE;
                    end
                end
                default: state <= PK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cmpAddr <= sweepAddr;
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the histogram testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f histTop.f --top-module histTb -o histSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/histSim > sim.log 2>&1
simStatus=$?
cat sim.log

# the log decides the verdict
if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

//--- verif/histTb.sv
`timescale 1ns/1ps

module histTb import histPkg::*; ();

    localparam int COUNT_W = 8;
    localparam int BIN_OFFSET = 100;
    localparam int BIN_SHIFT = 2;
    localparam int MAX_COUNT = (1 << COUNT_W) - 1;
    localparam int PEAK_DELAY = NUM_BINS + 2;
    // 4 runs of roughly clear + sweep + readback + up to 400 hit cycles, with margin
    localparam int MAX_CYCLES = 3000;

    logic clk;
    logic res;
    logic start;
    logic hit;
    logic [TS_W-1:0] timestamp;
    logic acqEnd;
    logic [BIN_W-1:0] rdAddr;
    logic armed;
    logic busy;
    logic histDone;
    logic peakValid;
    logic [BIN_W-1:0] peakBin;
    logic [COUNT_W-1:0] peakCount;
    logic [COUNT_W-1:0] rdData;

    // expected counts per bin
    int model [NUM_BINS];
    int unsigned seed;
    int cycles;
    int doneAt;
    int reports;
    logic waitPeak;
    logic afterPeak;

    histTop #(.COUNT_W(COUNT_W), .BIN_OFFSET(BIN_OFFSET), .BIN_SHIFT(BIN_SHIFT)) dut0 (
        .clk(clk), .res(res), .start(start), .hit(hit), .timestamp(timestamp),
        .acqEnd(acqEnd), .rdAddr(rdAddr), .armed(armed), .busy(busy),
        .histDone(histDone), .peakValid(peakValid), .peakBin(peakBin),
        .peakCount(peakCount), .rdData(rdData)
    );

    always #4 clk = ~clk;

    function automatic int unsigned lcgNext(input int unsigned s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // offset, shift, range check, then saturating count
    function automatic void countHit(input int ts);
        int b;
        if (ts >= BIN_OFFSET) begin
            b = (ts - BIN_OFFSET) >> BIN_SHIFT;
            if (b < NUM_BINS) begin
                model[b] = (model[b] >= MAX_COUNT) ? MAX_COUNT : model[b] + 1;
            end
        end
    endfunction

    // lowest bin holding the largest count
    function automatic int refPeak();
        int best;
        best = 0;
        for (int i = 1; i < NUM_BINS; i++) begin
            if (model[i] > model[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic check(input string name, input logic [31:0] expV, input logic [31:0] actV);
        if (expV !== actV) begin
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, expV, actV);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // inputs move 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // armed must rise after the full clear sweep, so the next edge takes the first hit
    task automatic beginRun();
        int waited;
        for (int i = 0; i < NUM_BINS; i++) begin
            model[i] = 0;
        end
        start = 1'b1;
        tick();
        start = 1'b0;
        waited = 0;
        while (!armed) begin
            tick();
            waited++;
        end
        check("armed delay", NUM_BINS, waited);
    endtask

    task automatic sendHit(input int ts, input logic withEnd);
        hit = 1'b1;
        timestamp = TS_W'(ts);
        acqEnd = withEnd;
        countHit(ts);
        tick();
        hit = 1'b0;
        acqEnd = 1'b0;
    endtask

    task automatic endAcq();
        acqEnd = 1'b1;
        tick();
        acqEnd = 1'b0;
    endtask

    // wait for the report, then read every bin through the idle port
    task automatic readBack();
        while (!peakValid) begin
            tick();
        end
        for (int a = 0; a <= NUM_BINS; a++) begin
            if (a > 0) begin
                check($sformatf("rdData[%0d]", a - 1), model[a - 1], rdData);
            end
            if (a < NUM_BINS) begin
                rdAddr = BIN_W'(a);
            end
            tick();
        end
    endtask

    // peak timing, peak value and busy, sampled mid cycle
    always @(negedge clk) begin
        if (res) begin
            cycles++;
            if (cycles >= MAX_CYCLES) begin
                $display("timeout: the runs did not finish within %0d cycles", MAX_CYCLES);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end else begin
                if (afterPeak) begin
                    check("busy", 0, busy);
                end
                afterPeak = peakValid;
                if (peakValid) begin
                    check("busy", 1, busy);
                    check("peakValid delay", PEAK_DELAY, cycles - doneAt);
                    check("peakBin", refPeak(), peakBin);
                    check("peakCount", model[refPeak()], peakCount);
                    waitPeak = 1'b0;
                    reports++;
                end else if (waitPeak) begin
                    check("busy", 1, busy);
                    check("peakValid", 0, (cycles - doneAt > PEAK_DELAY) ? 1 : 0);
                end
                if (histDone) begin
                    doneAt = cycles;
                    waitPeak = 1'b1;
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        res = 1'b0;
        start = 1'b0;
        hit = 1'b0;
        timestamp = '0;
        acqEnd = 1'b0;
        rdAddr = '0;
        seed = 2094;
        cycles = 0;
        doneAt = -1000;
        reports = 0;
        waitPeak = 1'b0;
        afterPeak = 1'b0;
        repeat (8) @(posedge clk);
        #1 res = 1'b1;

        // idle outputs after reset
        check("armed", 0, armed);
        check("busy", 0, busy);
        check("histDone", 0, histDone);
        check("peakValid", 0, peakValid);
        check("peakBin", 0, peakBin);
        check("peakCount", 0, peakCount);
        tick();

        // random timestamps, half of them outside the window
        beginRun();
        for (int i = 0; i < 200; i++) begin
            seed = lcgNext(seed);
            sendHit(int'((seed >> 8) % 512), 1'b0);
            seed = lcgNext(seed);
            repeat ((seed >> 12) % 3) tick();
        end
        endAcq();
        readBack();

        // same bin back to back, then alternating neighbours
        beginRun();
        for (int i = 0; i < 6; i++) begin
            sendHit(BIN_OFFSET + 20 + i % 4, 1'b0);
        end
        for (int i = 0; i < 20; i++) begin
            sendHit(BIN_OFFSET + ((7 + i % 2) << BIN_SHIFT), 1'b0);
        end
        // window edges and far outliers
        sendHit(BIN_OFFSET - 1, 1'b0);
        sendHit(BIN_OFFSET, 1'b0);
        sendHit(BIN_OFFSET + 255, 1'b0);
        sendHit(BIN_OFFSET + 256, 1'b0);
        sendHit(0, 1'b0);
        sendHit(4095, 1'b0);
        // last hit shares the edge with acqEnd
        sendHit(BIN_OFFSET + 21, 1'b1);
        readBack();

        // one bin driven past full scale
        beginRun();
        for (int i = 0; i < 300; i++) begin
            sendHit(BIN_OFFSET + 80 + i % 4, 1'b0);
        end
        endAcq();
        readBack();
        check("saturated peakBin", 20, peakBin);
        check("saturated peakCount", MAX_COUNT, peakCount);

        // tie between bins 30 and 10, lower one wins
        beginRun();
        for (int i = 0; i < 6; i++) begin
            sendHit(BIN_OFFSET + (((i % 2) ? 10 : 30) << BIN_SHIFT) + i % 4, 1'b0);
        end
        sendHit(BIN_OFFSET + (50 << BIN_SHIFT), 1'b0);
        sendHit(BIN_OFFSET + (50 << BIN_SHIFT) + 3, 1'b0);
        endAcq();
        readBack();
        check("tied peakBin", 10, peakBin);

        check("peak reports", 4, reports);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
